/* include/cpu_params.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define WORD_W      16
`define REG_IDX_W   3
`define NUM_REGS    8
`define DMEM_DEPTH  64
`define DMEM_ADDR_W 6
`define ALU_OP_W    4
`define MEM_OP_W    2

// opcodes, instr[15:12]
`define OP_RTYPE 4'd0
`define OP_ADDI  4'd1
`define OP_LW    4'd2
`define OP_SW    4'd3
`define OP_BEQ   4'd4
`define OP_BNE   4'd5

// r-type funct, instr[2:0]
`define FN_ADD 3'd0
`define FN_SUB 3'd1
`define FN_AND 3'd2
`define FN_OR  3'd3
`define FN_XOR 3'd4
`define FN_SLT 3'd5

`define ALU_ADD 4'd0
`define ALU_SUB 4'd1
`define ALU_AND 4'd2
`define ALU_OR  4'd3
`define ALU_XOR 4'd4
`define ALU_SLT 4'd5

`define MEM_NONE  2'd0  // must stay zero, a bubble is all zeros
`define MEM_LOAD  2'd1
`define MEM_STORE 2'd2

`endif

/* logic/cpu_pkg.sv */
`default_nettype none

`include "cpu_params.svh"

package cpu_pkg;

    typedef logic [`WORD_W-1:0]    word_t;     // data, instruction and pc
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;  // r0..r7
    typedef logic [`ALU_OP_W-1:0]  alu_op_t;
    typedef logic [`MEM_OP_W-1:0]  mem_op_t;

endpackage

`default_nettype wire

/* logic/id_ex_if.sv */
`timescale 1ns/1ps
`default_nettype none

// decoded instruction bundle, all zeros is a bubble
interface id_ex_if;
    import cpu_pkg::*;

    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;
    word_t    reg_read_data_1;
    word_t    reg_read_data_2;
    word_t    immediate;
    word_t    address;          // branch target
    logic     reg_dst;          // rd instead of rt
    logic     mem_to_reg;
    alu_op_t  alu_op;
    mem_op_t  mem_op;
    logic     alu_src;          // immediate as operand b
    logic     reg_write;
    logic     beq;
    logic     bne;

    modport source (
        output rs, rt, rd, reg_read_data_1, reg_read_data_2, immediate, address,
        output reg_dst, mem_to_reg, alu_op, mem_op, alu_src, reg_write, beq, bne
    );

    modport sink (
        input rs, rt, rd, reg_read_data_1, reg_read_data_2, immediate, address,
        input reg_dst, mem_to_reg, alu_op, mem_op, alu_src, reg_write, beq, bne
    );

endinterface

`default_nettype wire

/* logic/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module reg_file (
    input  logic              clk,
    input  logic              reset,
    input  cpu_pkg::reg_idx_t rd_addr_1,
    input  cpu_pkg::reg_idx_t rd_addr_2,
    output cpu_pkg::word_t    rd_data_1,
    output cpu_pkg::word_t    rd_data_2,
    input  logic              wr_en,
    input  cpu_pkg::reg_idx_t wr_addr,
    input  cpu_pkg::word_t    wr_data
);
    import cpu_pkg::*;

    word_t regs [`NUM_REGS];

    // r0 reads zero and a same-cycle write passes straight through
    function automatic word_t read_port(reg_idx_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wr_en && wr_addr == addr) begin
            return wr_data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    always_comb begin
        rd_data_1 = read_port(rd_addr_1);
        rd_data_2 = read_port(rd_addr_2);
    end

    r0_stays_zero: assert property (@(posedge clk) disable iff (reset)
        wr_en && wr_addr == '0 |=> regs[0] == '0);

endmodule

`default_nettype wire

/* logic/instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module instr_decoder (
    input  cpu_pkg::word_t    instr,
    input  cpu_pkg::word_t    pc,
    input  logic              instr_valid,
    input  cpu_pkg::word_t    rd_data_1,
    input  cpu_pkg::word_t    rd_data_2,
    output cpu_pkg::reg_idx_t rd_addr_1,
    output cpu_pkg::reg_idx_t rd_addr_2,
    id_ex_if.source           bus
);
    import cpu_pkg::*;

    logic [3:0] opcode;
    logic [2:0] funct;
    reg_idx_t   rs;
    reg_idx_t   rt;
    reg_idx_t   rd;
    word_t      imm_ext;
    logic       live;       // recognised op with instr_valid
    logic       c_reg_dst;
    logic       c_mem_to_reg;
    alu_op_t    c_alu_op;
    mem_op_t    c_mem_op;
    logic       c_alu_src;
    logic       c_reg_write;
    logic       c_beq;
    logic       c_bne;

    assign opcode  = instr[15:12];
    assign rs      = instr[11:9];
    assign rt      = instr[8:6];
    assign rd      = instr[5:3];
    assign funct   = instr[2:0];
    assign imm_ext = {{(`WORD_W-6){instr[5]}}, instr[5:0]};

    assign rd_addr_1 = rs;
    assign rd_addr_2 = rt;

    always_comb begin
        live         = instr_valid;
        c_reg_dst    = 1'b0;
        c_mem_to_reg = 1'b0;
        c_alu_op     = `ALU_ADD;
        c_mem_op     = `MEM_NONE;
        c_alu_src    = 1'b0;
        c_reg_write  = 1'b0;
        c_beq        = 1'b0;
        c_bne        = 1'b0;
        case (opcode)
            `OP_RTYPE: begin
                c_reg_dst   = 1'b1;
                c_reg_write = 1'b1;
                case (funct)
                    `FN_ADD: c_alu_op = `ALU_ADD;
                    `FN_SUB: c_alu_op = `ALU_SUB;
                    `FN_AND: c_alu_op = `ALU_AND;
                    `FN_OR:  c_alu_op = `ALU_OR;
                    `FN_XOR: c_alu_op = `ALU_XOR;
                    `FN_SLT: c_alu_op = `ALU_SLT;
                    default: live = 1'b0;  // spare funct codes act as nop
                endcase
            end
            `OP_ADDI: begin
                c_alu_src   = 1'b1;
                c_reg_write = 1'b1;
            end
            `OP_LW: begin
                c_alu_src    = 1'b1;
                c_mem_op     = `MEM_LOAD;
                c_mem_to_reg = 1'b1;
                c_reg_write  = 1'b1;
            end
            `OP_SW: begin
                c_alu_src = 1'b1;
                c_mem_op  = `MEM_STORE;
            end
            `OP_BEQ: c_beq = 1'b1;
            `OP_BNE: c_bne = 1'b1;
            default: live = 1'b0;
        endcase
    end

    always_comb begin
        bus.rs              = live ? rs : '0;
        bus.rt              = live ? rt : '0;
        bus.rd              = live ? rd : '0;
        bus.reg_read_data_1 = live ? rd_data_1 : '0;
        bus.reg_read_data_2 = live ? rd_data_2 : '0;
        bus.immediate       = live ? imm_ext : '0;
        bus.address         = live ? pc + 1'b1 + imm_ext : '0;  // pc + 1 + imm
        bus.reg_dst         = live & c_reg_dst;
        bus.mem_to_reg      = live & c_mem_to_reg;
        bus.alu_op          = live ? c_alu_op : '0;
        bus.mem_op          = live ? c_mem_op : '0;
        bus.alu_src         = live & c_alu_src;
        bus.reg_write       = live & c_reg_write;
        bus.beq             = live & c_beq;
        bus.bne             = live & c_bne;
    end

endmodule

`default_nettype wire

/* logic/hazard_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module hazard_unit (
    input  cpu_pkg::word_t instr,
    input  logic           instr_valid,
    id_ex_if.sink          ex,
    output logic           stall
);
    import cpu_pkg::*;

    logic [3:0] opcode;
    reg_idx_t   id_rs;
    reg_idx_t   id_rt;
    logic       uses_rs;
    logic       uses_rt;
    logic       load_in_ex;

    assign opcode = instr[15:12];
    assign id_rs  = instr[11:9];
    assign id_rt  = instr[8:6];

    always_comb begin
        uses_rs = 1'b0;
        uses_rt = 1'b0;
        if (instr_valid) begin
            case (opcode)
                `OP_RTYPE, `OP_SW, `OP_BEQ, `OP_BNE: begin
                    uses_rs = 1'b1;
                    uses_rt = 1'b1;
                end
                `OP_ADDI, `OP_LW: uses_rs = 1'b1;  // rt is the destination here
                default: ;
            endcase
        end
    end

    // only loads take their result from memory
    assign load_in_ex = ex.mem_to_reg && ex.rt != '0;

    assign stall = load_in_ex &&
                   ((uses_rs && id_rs == ex.rt) || (uses_rt && id_rt == ex.rt));

endmodule

`default_nettype wire

/* logic/id_ex_register.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module id_ex_register (
    input  logic     clk,
    input  logic     reset,
    input  logic     stall,
    input  logic     flush,
    id_ex_if.sink    in,
    id_ex_if.source  out
);

    always_ff @(posedge clk) begin
        if (reset || flush || stall) begin  // load a bubble
            out.rs              <= '0;
            out.rt              <= '0;
            out.rd              <= '0;
            out.reg_read_data_1 <= '0;
            out.reg_read_data_2 <= '0;
            out.immediate       <= '0;
            out.address         <= '0;
            out.reg_dst         <= 1'b0;
            out.mem_to_reg      <= 1'b0;
            out.alu_op          <= '0;
            out.mem_op          <= '0;
            out.alu_src         <= 1'b0;
            out.reg_write       <= 1'b0;
            out.beq             <= 1'b0;
            out.bne             <= 1'b0;
        end else begin
            out.rs              <= in.rs;
            out.rt              <= in.rt;
            out.rd              <= in.rd;
            out.reg_read_data_1 <= in.reg_read_data_1;
            out.reg_read_data_2 <= in.reg_read_data_2;
            out.immediate       <= in.immediate;
            out.address         <= in.address;
            out.reg_dst         <= in.reg_dst;
            out.mem_to_reg      <= in.mem_to_reg;
            out.alu_op          <= in.alu_op;
            out.mem_op          <= in.mem_op;
            out.alu_src         <= in.alu_src;
            out.reg_write       <= in.reg_write;
            out.beq             <= in.beq;
            out.bne             <= in.bne;
        end
    end

    // the slot behind a taken branch must not touch state
    flush_kills_slot: assert property (@(posedge clk) disable iff (reset)
        flush |=> !out.reg_write && out.mem_op == `MEM_NONE);

endmodule

`default_nettype wire

/* logic/exec_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module exec_stage (
    input  logic              clk,
    input  logic              reset,
    id_ex_if.sink             ex,
    input  logic              wb_en,
    input  cpu_pkg::reg_idx_t wb_reg,
    input  cpu_pkg::word_t    wb_data,
    output logic              branch_taken,
    output cpu_pkg::word_t    branch_target,
    output cpu_pkg::word_t    mem_alu_result,
    output cpu_pkg::word_t    mem_store_data,
    output cpu_pkg::reg_idx_t mem_dest,
    output logic              mem_reg_write,
    output cpu_pkg::mem_op_t  mem_op
);
    import cpu_pkg::*;

    word_t    op_a;
    word_t    fwd_b;
    word_t    alu_b;
    word_t    alu_y;
    reg_idx_t dest;

    // newest producer wins and a load in ex_mem has no data yet
    function automatic word_t forward(reg_idx_t src, word_t rf_val);
        if (mem_reg_write && mem_op != `MEM_LOAD && mem_dest != '0 && mem_dest == src) begin
            return mem_alu_result;
        end
        if (wb_en && wb_reg == src) begin
            return wb_data;
        end
        return rf_val;
    endfunction

    always_comb begin
        op_a  = forward(ex.rs, ex.reg_read_data_1);
        fwd_b = forward(ex.rt, ex.reg_read_data_2);
    end

    assign alu_b = ex.alu_src ? ex.immediate : fwd_b;
    assign dest  = ex.reg_dst ? ex.rd : ex.rt;

    always_comb begin
        case (ex.alu_op)
            `ALU_ADD: alu_y = op_a + alu_b;
            `ALU_SUB: alu_y = op_a - alu_b;
            `ALU_AND: alu_y = op_a & alu_b;
            `ALU_OR:  alu_y = op_a | alu_b;
            `ALU_XOR: alu_y = op_a ^ alu_b;
            `ALU_SLT: alu_y = {{(`WORD_W-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
            default:  alu_y = op_a + alu_b;
        endcase
    end

    assign branch_taken  = (ex.beq && op_a == fwd_b) || (ex.bne && op_a != fwd_b);
    assign branch_target = ex.address;

    // ex_mem control
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_dest      <= '0;
            mem_reg_write <= 1'b0;
            mem_op        <= `MEM_NONE;
        end else begin
            mem_dest      <= dest;
            mem_reg_write <= ex.reg_write;
            mem_op        <= ex.mem_op;
        end
    end

    // ex_mem payload
    always_ff @(posedge clk) begin
        mem_alu_result <= alu_y;
        mem_store_data <= fwd_b;  // store source after forwarding
    end

    // the following slot is always flushed
    single_branch_pulse: assert property (@(posedge clk) disable iff (reset)
        branch_taken |=> !branch_taken);

endmodule

`default_nettype wire

/* logic/mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module mem_stage (
    input  logic              clk,
    input  logic              reset,
    input  cpu_pkg::word_t    alu_result,
    input  cpu_pkg::word_t    store_data,
    input  cpu_pkg::reg_idx_t dest,
    input  logic              reg_write,
    input  cpu_pkg::mem_op_t  mem_op,
    output logic              wb_en,
    output cpu_pkg::reg_idx_t wb_reg,
    output cpu_pkg::word_t    wb_data
);
    import cpu_pkg::*;

    word_t                   dmem [`DMEM_DEPTH];
    logic [`DMEM_ADDR_W-1:0] addr;

    assign addr = alu_result[`DMEM_ADDR_W-1:0];  // wraps at 64 words

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (mem_op == `MEM_STORE) begin
            dmem[addr] <= store_data;
        end
    end

    // mem_wb control
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_en  <= 1'b0;
            wb_reg <= '0;
        end else begin
            wb_en  <= reg_write && dest != '0;  // r0 writes vanish here
            wb_reg <= dest;
        end
    end

    always_ff @(posedge clk) begin
        wb_data <= (mem_op == `MEM_LOAD) ? dmem[addr] : alu_result;
    end

endmodule

`default_nettype wire

/* logic/core_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module core_pipe (
    input  logic              clk,
    input  logic              reset,
    input  cpu_pkg::word_t    instr,
    input  cpu_pkg::word_t    pc,
    input  logic              instr_valid,
    output logic              stall,
    output logic              branch_taken,
    output cpu_pkg::word_t    branch_target,
    output logic              wb_en,
    output cpu_pkg::reg_idx_t wb_reg,
    output cpu_pkg::word_t    wb_data
);
    import cpu_pkg::*;

    reg_idx_t rf_rd_addr_1;
    reg_idx_t rf_rd_addr_2;
    word_t    rf_rd_data_1;
    word_t    rf_rd_data_2;
    word_t    mem_alu_result;
    word_t    mem_store_data;
    reg_idx_t mem_dest;
    logic     mem_reg_write;
    mem_op_t  mem_op;

    id_ex_if dec_bus ();
    id_ex_if ex_bus ();

    reg_file i_reg_file (
        .clk       (clk),
        .reset     (reset),
        .rd_addr_1 (rf_rd_addr_1),
        .rd_addr_2 (rf_rd_addr_2),
        .rd_data_1 (rf_rd_data_1),
        .rd_data_2 (rf_rd_data_2),
        .wr_en     (wb_en),
        .wr_addr   (wb_reg),
        .wr_data   (wb_data)
    );

    instr_decoder i_instr_decoder (
        .instr       (instr),
        .pc          (pc),
        .instr_valid (instr_valid),
        .rd_data_1   (rf_rd_data_1),
        .rd_data_2   (rf_rd_data_2),
        .rd_addr_1   (rf_rd_addr_1),
        .rd_addr_2   (rf_rd_addr_2),
        .bus         (dec_bus.source)
    );

    hazard_unit i_hazard_unit (
        .instr       (instr),
        .instr_valid (instr_valid),
        .ex          (ex_bus.sink),
        .stall       (stall)
    );

    id_ex_register i_id_ex_register (
        .clk   (clk),
        .reset (reset),
        .stall (stall),
        .flush (branch_taken),  // flush wins over stall, both give a bubble
        .in    (dec_bus.sink),
        .out   (ex_bus.source)
    );

    exec_stage i_exec_stage (
        .clk            (clk),
        .reset          (reset),
        .ex             (ex_bus.sink),
        .wb_en          (wb_en),
        .wb_reg         (wb_reg),
        .wb_data        (wb_data),
        .branch_taken   (branch_taken),
        .branch_target  (branch_target),
        .mem_alu_result (mem_alu_result),
        .mem_store_data (mem_store_data),
        .mem_dest       (mem_dest),
        .mem_reg_write  (mem_reg_write),
        .mem_op         (mem_op)
    );

    mem_stage i_mem_stage (
        .clk        (clk),
        .reset      (reset),
        .alu_result (mem_alu_result),
        .store_data (mem_store_data),
        .dest       (mem_dest),
        .reg_write  (mem_reg_write),
        .mem_op     (mem_op),
        .wb_en      (wb_en),
        .wb_reg     (wb_reg),
        .wb_data    (wb_data)
    );

endmodule

`default_nettype wire

/* testbench/core_pipe_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module core_pipe_tb;
    import cpu_pkg::*;

    localparam int num_instr  = 39;  // instructions over all test programs
    localparam int clk_period = 4;

    logic     clk;
    logic     reset;
    word_t    instr;
    word_t    pc;
    logic     instr_valid;
    logic     stall;
    logic     branch_taken;
    word_t    branch_target;
    logic     wb_en;
    reg_idx_t wb_reg;
    word_t    wb_data;

    word_t    prog [$];
    reg_idx_t got_reg [$];
    word_t    got_data [$];
    reg_idx_t exp_reg [$];
    word_t    exp_data [$];
    word_t    model_regs [`NUM_REGS];
    word_t    model_mem [`DMEM_DEPTH];

    logic        br_pending;     // last accepted instruction was a branch
    logic        br_exp_taken;
    word_t       br_exp_target;
    int          stall_count;
    int          error_count;
    int          check_count;
    int          test_count;
    int unsigned seed;

    core_pipe i_core_pipe (.*);

    always #(clk_period / 2) clk = ~clk;

    // writeback events in arrival order
    always @(negedge clk) begin
        if (!reset && wb_en) begin
            got_reg.push_back(wb_reg);
            got_data.push_back(wb_data);
        end
    end

    initial begin
        #((num_instr + 20) * clk_period * 4);
        $display("watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

    task automatic check_word(string name, word_t got, word_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_reg(string name, reg_idx_t got, reg_idx_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    function automatic word_t r_op(logic [2:0] fn, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
        return {`OP_RTYPE, rs, rt, rd, fn};
    endfunction

    function automatic word_t i_op(logic [3:0] op, reg_idx_t rt, reg_idx_t rs, logic [5:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic model_write(reg_idx_t dst, word_t val);
        if (dst != 3'd0) begin  // r0 writes are dropped
            model_regs[dst] = val;
            exp_reg.push_back(dst);
            exp_data.push_back(val);
        end
    endtask

    // executes one accepted instruction in program order
    task automatic model_exec(word_t ins, int pc_val);
        logic [3:0] op;
        logic [2:0] fn;
        reg_idx_t   rs;
        reg_idx_t   rt;
        reg_idx_t   rd;
        word_t      imm;
        word_t      a;
        word_t      b;
        logic [5:0] maddr;
        op    = ins[15:12];
        rs    = ins[11:9];
        rt    = ins[8:6];
        rd    = ins[5:3];
        fn    = ins[2:0];
        imm   = {{10{ins[5]}}, ins[5:0]};
        a     = model_regs[rs];
        b     = model_regs[rt];
        maddr = 6'(a + imm);
        case (op)
            `OP_RTYPE: begin
                case (fn)
                    `FN_ADD: model_write(rd, a + b);
                    `FN_SUB: model_write(rd, a - b);
                    `FN_AND: model_write(rd, a & b);
                    `FN_OR:  model_write(rd, a | b);
                    `FN_XOR: model_write(rd, a ^ b);
                    `FN_SLT: model_write(rd, ($signed(a) < $signed(b)) ? 16'd1 : 16'd0);
                    default: ;
                endcase
            end
            `OP_ADDI: model_write(rt, a + imm);
            `OP_LW:   model_write(rt, model_mem[maddr]);
            `OP_SW:   model_mem[maddr] = b;
            `OP_BEQ, `OP_BNE: begin
                br_pending    = 1'b1;
                br_exp_taken  = (op == `OP_BEQ) ? (a == b) : (a != b);
                br_exp_target = word_t'(pc_val) + 16'd1 + imm;
            end
            default: ;
        endcase
    endtask

    // presents prog one slot per cycle, holds on stall, follows taken branches
    task automatic run_program();
        int    idx;
        logic  taken_now;
        logic  stall_now;
        word_t target_now;
        idx         = 0;
        stall_count = 0;
        br_pending  = 1'b0;
        while (idx < prog.size() || br_pending) begin
            if (idx < prog.size()) begin
                instr       = prog[idx];
                pc          = word_t'(idx);
                instr_valid = 1'b1;
            end else begin
                instr_valid = 1'b0;
            end
            #2;  // mid-cycle, ex settled
            check_flag("branch_taken", branch_taken, br_pending && br_exp_taken);
            if (br_pending) begin
                check_word("branch_target", branch_target, br_exp_target);
            end
            taken_now  = branch_taken;
            stall_now  = stall;
            target_now = branch_target;
            @(posedge clk);
            #1;
            br_pending = 1'b0;
            if (taken_now) begin
                idx = int'(target_now);  // slot was flushed
            end else if (instr_valid && stall_now) begin
                stall_count++;
            end else if (instr_valid) begin
                model_exec(prog[idx], idx);
                idx++;
            end
        end
        instr_valid = 1'b0;
        prog.delete();
    endtask

    task automatic finish_test(string name, int errs);
        int waited;
        int n;
        waited = 0;
        while (got_reg.size() < exp_reg.size() && waited < 12) begin
            @(posedge clk);
            #1;
            waited++;
        end
        repeat (4) begin  // room for stray writebacks
            @(posedge clk);
            #1;
        end
        if (got_reg.size() != exp_reg.size()) begin
            error_count++;
            $display("%s saw %0d writebacks where %0d were expected",
                     name, got_reg.size(), exp_reg.size());
        end
        n = (got_reg.size() < exp_reg.size()) ? got_reg.size() : exp_reg.size();
        for (int i = 0; i < n; i++) begin
            check_reg("wb_reg", got_reg[i], exp_reg[i]);
            check_word("wb_data", got_data[i], exp_data[i]);
        end
        got_reg.delete();
        got_data.delete();
        exp_reg.delete();
        exp_data.delete();
        test_count++;
        if (error_count == errs) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, error_count - errs);
        end
    endtask

    task automatic test_reset_idle();
        int errs;
        errs = error_count;
        check_flag("stall", stall, 1'b0);
        check_flag("branch_taken", branch_taken, 1'b0);
        check_flag("wb_en", wb_en, 1'b0);
        repeat (8) begin
            instr       = word_t'($urandom);
            pc          = word_t'($urandom);
            instr_valid = 1'b0;
            #2;
            check_flag("stall", stall, 1'b0);
            check_flag("branch_taken", branch_taken, 1'b0);
            @(posedge clk);
            #1;
        end
        finish_test("reset_idle", errs);
    endtask

    task automatic test_forwarding();
        int errs;
        errs = error_count;
        prog.push_back(i_op(`OP_ADDI, 3'd1, 3'd0, 6'($urandom)));
        prog.push_back(i_op(`OP_ADDI, 3'd2, 3'd1, 6'($urandom)));  // from ex_mem
        prog.push_back(r_op(`FN_ADD, 3'd3, 3'd1, 3'd2));           // r1 from wb
        prog.push_back(r_op(`FN_SUB, 3'd4, 3'd3, 3'd1));           // r1 via rf bypass
        prog.push_back(r_op(`FN_AND, 3'd5, 3'd4, 3'd2));
        prog.push_back(r_op(`FN_OR, 3'd6, 3'd5, 3'd3));
        prog.push_back(r_op(`FN_XOR, 3'd7, 3'd6, 3'd4));
        prog.push_back(r_op(`FN_SLT, 3'd1, 3'd7, 3'd3));
        prog.push_back(r_op(`FN_SLT, 3'd2, 3'd3, 3'd7));
        prog.push_back(i_op(`OP_ADDI, 3'd3, 3'd1, 6'($urandom)));
        run_program();
        finish_test("forwarding", errs);
    endtask

    task automatic test_r0_writes();
        int errs;
        errs = error_count;
        prog.push_back(i_op(`OP_ADDI, 3'd0, 3'd0, 6'd21));
        prog.push_back(r_op(`FN_ADD, 3'd0, 3'd1, 3'd2));
        prog.push_back(r_op(`FN_ADD, 3'd3, 3'd0, 3'd0));
        prog.push_back(i_op(`OP_ADDI, 3'd4, 3'd0, 6'd9));
        prog.push_back(r_op(`FN_OR, 3'd5, 3'd0, 3'd4));
        run_program();
        finish_test("r0_writes", errs);
    endtask

    task automatic test_load_store();
        int errs;
        errs = error_count;
        prog.push_back(i_op(`OP_ADDI, 3'd1, 3'd0, 6'd10));
        prog.push_back(i_op(`OP_ADDI, 3'd2, 3'd0, 6'($urandom)));
        prog.push_back(i_op(`OP_SW, 3'd2, 3'd1, 6'd3));
        prog.push_back(i_op(`OP_LW, 3'd3, 3'd1, 6'd3));
        prog.push_back(r_op(`FN_ADD, 3'd4, 3'd3, 3'd2));  // load-use
        prog.push_back(i_op(`OP_LW, 3'd5, 3'd0, 6'd13));  // same word as 3(r1)
        prog.push_back(i_op(`OP_ADDI, 3'd6, 3'd0, 6'd1));
        prog.push_back(i_op(`OP_LW, 3'd7, 3'd0, 6'd40));
        run_program();
        if (stall_count != 1) begin
            error_count++;
            $display("load-use stall was raised %0d times instead of once", stall_count);
        end
        finish_test("load_store", errs);
    endtask

    task automatic test_branches();
        int errs;
        errs = error_count;
        prog.push_back(i_op(`OP_ADDI, 3'd1, 3'd0, 6'd5));
        prog.push_back(i_op(`OP_ADDI, 3'd2, 3'd0, 6'd5));
        prog.push_back(i_op(`OP_ADDI, 3'd3, 3'd0, 6'd7));
        prog.push_back(i_op(`OP_BEQ, 3'd2, 3'd1, 6'd2));   // taken
        prog.push_back(i_op(`OP_ADDI, 3'd7, 3'd0, 6'h3f));
        prog.push_back(i_op(`OP_ADDI, 3'd7, 3'd0, 6'h3e));
        prog.push_back(i_op(`OP_BNE, 3'd2, 3'd1, 6'd1));   // not taken
        prog.push_back(i_op(`OP_ADDI, 3'd4, 3'd0, 6'd11));
        prog.push_back(i_op(`OP_BEQ, 3'd3, 3'd1, 6'd1));   // not taken
        prog.push_back(i_op(`OP_BNE, 3'd3, 3'd1, 6'd2));   // taken
        prog.push_back(i_op(`OP_ADDI, 3'd7, 3'd0, 6'h3d));
        prog.push_back(i_op(`OP_ADDI, 3'd7, 3'd0, 6'h3c));
        prog.push_back(i_op(`OP_ADDI, 3'd5, 3'd1, 6'd2));
        prog.push_back(i_op(`OP_BEQ, 3'd3, 3'd5, 6'd1));   // taken, r5 forwarded
        prog.push_back(i_op(`OP_ADDI, 3'd7, 3'd0, 6'h3b));
        prog.push_back(i_op(`OP_ADDI, 3'd6, 3'd5, 6'd1));
        run_program();
        finish_test("branches", errs);
    endtask

    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        instr         = '0;
        pc            = '0;
        instr_valid   = 1'b0;
        br_pending    = 1'b0;
        br_exp_taken  = 1'b0;
        br_exp_target = '0;
        stall_count   = 0;
        error_count   = 0;
        check_count   = 0;
        test_count    = 0;
        seed          = 32'hf4e9_60ed;
        void'($urandom(seed));
        for (int i = 0; i < `NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < `DMEM_DEPTH; i++) begin
            model_mem[i] = '0;
        end
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        test_reset_idle();
        test_forwarding();
        test_r0_writes();
        test_load_store();
        test_branches();
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
logic/cpu_pkg.sv
logic/id_ex_if.sv
logic/reg_file.sv
logic/instr_decoder.sv
logic/hazard_unit.sv
logic/id_ex_register.sv
logic/exec_stage.sv
logic/mem_stage.sv
logic/core_pipe.sv
testbench/core_pipe_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, then run; the exit status follows the pass message
verilator --binary --timing --assert --top-module core_pipe_tb \
    -f verilog.f -o core_pipe_sim \
    && ./obj_dir/core_pipe_sim 2>&1 | tee /dev/stderr | grep -q "^Simulation passed$" \
    && exit 0 \
    || exit 1
